//--- rom.hex
// one 64-bit word per line: upper 32 bits at addr+4, lower 32 bits at addr
0020011300100093
0040021300300193
0060031300500293
0080041300700393
00a0051300900493
00c0061300b00593
00e0071300d00693
0100081300f00793
0120091301100893
01400a1301300993
01600b1301500a93
01800c1301700b93
01a00d1301900c93
01c00e1301b00d93
01e00f1301d00e93
002080b301f00f93

//--- list.f
fetch_pkg.sv
fetch_bus_if.sv
fetch_unit.sv
axil_fetch_master.sv
inst_rom.sv
fetch_top.sv
fetch_checker.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - fetch_bus_if.sv
  - fetch_unit.sv
  - axil_fetch_master.sv
  - inst_rom.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_checker.sv
      - tb_fetch_top.sv

//--- tb_fetch_top.sv
//////////////////////////////
// testbench top: clock, reset, random
// redirect and enable stimulus
//////////////////////////////

`timescale 1ns/1ps

module tb_fetch_top;

  localparam int ROM_WORDS      = fetch_pkg::ROM_WORDS;
  localparam int NUM_TESTS      = 120;
  localparam int SEQ_TESTS      = 40;   // long enough to wrap the rom
  localparam int ENA_TESTS_FROM = 80;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;
  localparam int OFF_BITS       = $clog2(ROM_WORDS) + 1;  // instruction slots

  logic              clk;
  logic              rst;
  logic              i_ena;
  logic              i_pc_jmp;
  fetch_pkg::addr_t  i_pc_jmpaddr;
  fetch_pkg::addr_t  o_pc;
  fetch_pkg::addr_t  o_pc_pred;
  fetch_pkg::inst_t  o_inst;
  logic              o_fetched;
  logic              o_nocmt;
  int                errors;
  int                checks;
  int                cycles;
  logic [31:0]       lfsr_state;

  fetch_top #(.ROM_WORDS(ROM_WORDS)) dut_i (
    .clk(clk), .rst(rst), .i_ena(i_ena), .i_pc_jmp(i_pc_jmp),
    .i_pc_jmpaddr(i_pc_jmpaddr), .o_pc(o_pc), .o_pc_pred(o_pc_pred),
    .o_inst(o_inst), .o_fetched(o_fetched), .o_nocmt(o_nocmt)
  );

  fetch_checker #(.ROM_WORDS(ROM_WORDS)) chk_i (
    .clk(clk), .rst(rst), .i_ena(i_ena), .i_pc_jmp(i_pc_jmp),
    .i_pc_jmpaddr(i_pc_jmpaddr), .i_pc(o_pc), .i_pc_pred(o_pc_pred),
    .i_inst(o_inst), .i_fetched(o_fetched), .i_nocmt(o_nocmt),
    .o_errors(errors), .o_checks(checks)
  );

  always #50 clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    int          k;
    v = 0;
    for (k = 0; k < n; k++) begin
      v = (v << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // starts and ends on a rising edge
  task automatic run_test(input int t);
    int unsigned       delay;
    int unsigned       gap;
    int                err_before;
    fetch_pkg::addr_t  target;
    err_before = errors;
    if (t >= SEQ_TESTS && take_bits(1) == 1) begin
      delay = take_bits(2);
      repeat (delay) @(posedge clk);
      if (take_bits(2) == 0) begin
        target = o_pc_pred;  // stays on the predicted path
      end else begin
        target = fetch_pkg::PC_START + (fetch_pkg::addr_t'(take_bits(OFF_BITS)) << 2);
      end
      i_pc_jmp     <= 1'b1;
      i_pc_jmpaddr <= target;
      @(posedge clk);
      i_pc_jmp     <= 1'b0;
    end
    if (t >= ENA_TESTS_FROM && take_bits(1) == 1) begin
      gap = 1 + take_bits(4);
      i_ena <= 1'b0;
      repeat (gap) @(posedge clk);
      i_ena <= 1'b1;
    end
    do begin
      @(posedge clk);
    end while (!o_fetched);
    $display("test %0d: pc %h inst %h nocmt %0b %s", t, o_pc, o_inst, o_nocmt,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int t;
    clk          = 1'b0;
    rst          = 1'b1;
    i_ena        = 1'b0;
    i_pc_jmp     = 1'b0;
    i_pc_jmpaddr = '0;
    cycles       = 0;
    lfsr_state   = 32'he6ab;
    repeat (3) @(posedge clk);
    rst   <= 1'b0;
    i_ena <= 1'b1;
    for (t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- fetch_checker.sv
//////////////////////////////
// testbench checker, rom reference
// model and fetch sequence rules
//////////////////////////////

`timescale 1ns/1ps

module fetch_checker #(
  parameter int ROM_WORDS = fetch_pkg::ROM_WORDS
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ena,
  input  logic              i_pc_jmp,
  input  fetch_pkg::addr_t  i_pc_jmpaddr,
  input  fetch_pkg::addr_t  i_pc,
  input  fetch_pkg::addr_t  i_pc_pred,
  input  fetch_pkg::inst_t  i_inst,
  input  logic              i_fetched,
  input  logic              i_nocmt,
  output int                o_errors,
  output int                o_checks
);

  fetch_pkg::data_t  rom_img [ROM_WORDS];
  fetch_pkg::addr_t  exp_pc;       // next committed address
  fetch_pkg::addr_t  jmp_target;
  logic              flush_due;    // nop expected in the next pulse
  logic              ena_prev;     // i_ena as the dut sampled it
  int                low_fetches;  // fetches delivered while disabled

  initial begin
    $readmemh("rom.hex", rom_img);
    o_errors = 0;
    o_checks = 0;
  end

  // upper address bits alias, bit 2 picks the half
  function automatic fetch_pkg::inst_t ref_inst(input fetch_pkg::addr_t addr);
    fetch_pkg::data_t word;
    word = rom_img[(addr >> 3) % ROM_WORDS];
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    o_checks++;
    if (got !== want) begin
      o_errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic report_error(input string what);
    o_errors++;
    $display("error: %s at %0t", what, $time);
  endtask

  //////////////////////////////
  // compare on the falling edge
  //////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      exp_pc      = fetch_pkg::PC_START;
      flush_due   = 1'b0;
      low_fetches = 0;
      if (i_fetched || i_nocmt) begin
        report_error("fetch pulse while in reset");
      end
    end else begin
      if (ena_prev) begin
        low_fetches = 0;
      end
      if (i_nocmt && !i_fetched) begin
        report_error("o_nocmt high without o_fetched");
      end
      if (i_fetched && flush_due) begin
        compare_value("o_nocmt", 64'(i_nocmt), 64'(1'b1));
        compare_value("o_inst", 64'(i_inst), 64'(fetch_pkg::INST_NOP));
        compare_value("o_pc", i_pc, jmp_target);
        compare_value("o_pc_pred", i_pc_pred, jmp_target + 64'd4);
      end else if (i_fetched && i_nocmt) begin
        report_error("not-to-commit fetch without a flushing redirect");
      end else if (i_fetched) begin
        compare_value("o_pc", i_pc, exp_pc);
        compare_value("o_pc_pred", i_pc_pred, exp_pc + 64'd4);
        compare_value("o_inst", 64'(i_inst), 64'(ref_inst(exp_pc)));
        exp_pc = exp_pc + 64'd4;
        if (!ena_prev) begin
          low_fetches++;
        end
        if (low_fetches > 1) begin
          report_error("more than one fetch delivered after i_ena fell");
        end
      end else if (flush_due) begin
        report_error("flushing redirect produced no fetch pulse");
      end
      // only a target off the predicted path flushes
      flush_due = i_pc_jmp && (i_pc_jmpaddr != i_pc_pred);
      if (flush_due) begin
        jmp_target = i_pc_jmpaddr;
        exp_pc     = i_pc_jmpaddr;
      end
    end
    ena_prev = i_ena;
  end

endmodule

//--- fetch_top.sv
//////////////////////////////
// fetch front end top level
//////////////////////////////

`timescale 1ns/1ps

module fetch_top #(
  parameter int ROM_WORDS = fetch_pkg::ROM_WORDS
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ena,
  input  logic              i_pc_jmp,
  input  fetch_pkg::addr_t  i_pc_jmpaddr,
  output fetch_pkg::addr_t  o_pc,
  output fetch_pkg::addr_t  o_pc_pred,
  output fetch_pkg::inst_t  o_inst,
  output logic              o_fetched,
  output logic              o_nocmt
);

  // axi4-lite read channels
  fetch_pkg::addr_t  araddr;
  logic              arvalid;
  logic              arready;
  fetch_pkg::data_t  rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  fetch_bus_if fetch_bus ();

  fetch_unit u_fetch_unit (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_pc_jmp     (i_pc_jmp),
    .i_pc_jmpaddr (i_pc_jmpaddr),
    .bus          (fetch_bus),
    .o_pc         (o_pc),
    .o_pc_pred    (o_pc_pred),
    .o_inst       (o_inst),
    .o_fetched    (o_fetched),
    .o_nocmt      (o_nocmt)
  );

  axil_fetch_master u_master (
    .clk       (clk),
    .rst       (rst),
    .bus       (fetch_bus),
    .o_araddr  (araddr),
    .o_arvalid (arvalid),
    .i_arready (arready),
    .i_rdata   (rdata),
    .i_rresp   (rresp),
    .i_rvalid  (rvalid),
    .o_rready  (rready)
  );

  inst_rom #(
    .ROM_WORDS (ROM_WORDS)
  ) u_rom (
    .clk       (clk),
    .rst       (rst),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

endmodule

//--- inst_rom.sv
//////////////////////////////
// instruction rom as an axi4-lite
// read slave, loaded from rom.hex
//////////////////////////////

`timescale 1ns/1ps

module inst_rom #(
  parameter int ROM_WORDS = fetch_pkg::ROM_WORDS
) (
  input  logic              clk,
  input  logic              rst,
  input  fetch_pkg::addr_t  i_araddr,
  input  logic              i_arvalid,
  output logic              o_arready,
  output fetch_pkg::data_t  o_rdata,
  output logic [1:0]        o_rresp,
  output logic              o_rvalid,
  input  logic              i_rready
);

  localparam int IDX_W = $clog2(ROM_WORDS);

  fetch_pkg::data_t  mem [ROM_WORDS];
  fetch_pkg::data_t  rdata_q;
  logic              rvalid_q;
  logic [IDX_W-1:0]  rd_idx;
  logic              ar_hs;

  initial begin
    $readmemh("rom.hex", mem);
  end

  // upper address bits alias
  assign rd_idx    = i_araddr[3 +: IDX_W];
  assign ar_hs     = i_arvalid && o_arready;

  assign o_arready = !rvalid_q;  // one response at a time
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = rdata_q;
  assign o_rresp   = fetch_pkg::AXI_RESP_OKAY;

  //////////////////////////////
  // read channel
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (i_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_q <= mem[rd_idx];
    end
  end

  // no new address offered while a response waits
  a_one_pending: assert property (@(posedge clk) disable iff (rst)
    o_rvalid |-> !i_arvalid);

endmodule

//--- axil_fetch_master.sv
//////////////////////////////
// fetch bus to axi4-lite read master
//////////////////////////////

`timescale 1ns/1ps

module axil_fetch_master (
  input  logic              clk,
  input  logic              rst,
  fetch_bus_if.bus_mp       bus,
  output fetch_pkg::addr_t  o_araddr,
  output logic              o_arvalid,
  input  logic              i_arready,
  input  fetch_pkg::data_t  i_rdata,
  input  logic [1:0]        i_rresp,
  input  logic              i_rvalid,
  output logic              o_rready
);

  typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

  state_t            state;
  fetch_pkg::addr_t  araddr_q;
  fetch_pkg::data_t  rdata_q;
  logic              ack_q;
  logic              start;

  // a request still high in its ack cycle is already served
  assign start = (state == st_idle) && bus.req && !ack_q;

  assign o_araddr  = araddr_q;
  assign o_arvalid = (state == st_addr);
  assign o_rready  = (state == st_data);

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

  //////////////////////////////
  // read sequencing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      ack_q <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state)
        st_idle: if (start) state <= st_addr;
        st_addr: if (i_arready) state <= st_data;
        st_data: begin
          if (i_rvalid) begin
            state <= st_idle;
            ack_q <= 1'b1;  // one cycle after the r handshake
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      araddr_q <= bus.addr;
    end
    if (o_rready && i_rvalid) begin
      rdata_q <= i_rdata;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

  // rom never reports an error
  a_resp_okay: assert property (@(posedge clk) disable iff (rst)
    i_rvalid |-> (i_rresp == fetch_pkg::AXI_RESP_OKAY));

endmodule

//--- fetch_unit.sv
//////////////////////////////
// fetch unit: pc, redirect and flush,
// one request in flight on the fetch bus
//////////////////////////////

`timescale 1ns/1ps

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_ena,
  input  logic                  i_pc_jmp,
  input  fetch_pkg::addr_t      i_pc_jmpaddr,
  fetch_bus_if.fetch_mp         bus,
  output fetch_pkg::addr_t      o_pc,
  output fetch_pkg::addr_t      o_pc_pred,
  output fetch_pkg::inst_t      o_inst,
  output logic                  o_fetched,
  output logic                  o_nocmt
);

  typedef enum logic [1:0] {st_idle, st_wait, st_drop} state_t;

  state_t            state;
  fetch_pkg::addr_t  fetch_addr;   // next address to request
  fetch_pkg::addr_t  req_addr;     // address of the request on the bus
  fetch_pkg::addr_t  launch_addr;
  logic              flush;
  logic              good_ack;
  logic              bus_free;     // nothing outstanding after this cycle

  assign flush    = i_pc_jmp && (i_pc_jmpaddr != o_pc_pred);
  assign good_ack = bus.ack && (state == st_wait) && !flush;
  assign bus_free = (state == st_idle) || bus.ack;

  assign bus.req  = (state != st_idle);
  assign bus.addr = req_addr;

  always_comb begin
    launch_addr = fetch_addr;
    if (flush) begin
      launch_addr = i_pc_jmpaddr;
    end else if (good_ack) begin
      launch_addr = req_addr + 64'd4;
    end
  end

  //////////////////////////////
  // request sequencing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      fetch_addr <= fetch_pkg::PC_START;
    end else begin
      fetch_addr <= launch_addr;
      if (bus_free) begin
        state <= i_ena ? st_wait : st_idle;  // back to back when enabled
      end else if (flush) begin
        state <= st_drop;                    // old data is thrown away on ack
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_free && i_ena) begin
      req_addr <= launch_addr;
    end
  end

  //////////////////////////////
  // instruction output
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_fetched <= 1'b0;
      o_nocmt   <= 1'b0;
      o_pc      <= '0;
      o_pc_pred <= fetch_pkg::PC_START;
    end else begin
      o_fetched <= flush || good_ack;
      o_nocmt   <= flush;
      if (flush) begin
        o_pc      <= i_pc_jmpaddr;
        o_pc_pred <= i_pc_jmpaddr + 64'd4;
      end else if (good_ack) begin
        o_pc      <= req_addr;
        o_pc_pred <= req_addr + 64'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      o_inst <= fetch_pkg::INST_NOP;
    end else if (good_ack) begin
      o_inst <= req_addr[2] ? bus.rdata[63:32] : bus.rdata[31:0];  // half by bit 2
    end
  end

  // an ack only answers a request we raised
  a_no_ack_idle: assert property (@(posedge clk) disable iff (rst)
    bus.ack |-> (state != st_idle));

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    bus.req && !bus.ack |=> bus.req && $stable(bus.addr));

endmodule

//--- fetch_bus_if.sv
//////////////////////////////
// req/ack fetch bus between the
// fetch unit and the bus master
//////////////////////////////

`timescale 1ns/1ps

interface fetch_bus_if;

  logic              req;    // held until ack
  fetch_pkg::addr_t  addr;   // stable while req waits
  logic              ack;    // one cycle, completes the transfer
  fetch_pkg::data_t  rdata;  // valid with ack

  // requester side
  modport fetch_mp (
    output req,
    output addr,
    input  ack,
    input  rdata
  );

  // responder side
  modport bus_mp (
    input  req,
    input  addr,
    output ack,
    output rdata
  );

endinterface

//--- fetch_pkg.sv
//////////////////////////////
// types and constants shared by the
// instruction fetch front end
//////////////////////////////

package fetch_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  typedef logic [63:0] addr_t;  // byte address
  typedef logic [63:0] data_t;  // one bus beat, two instructions
  typedef logic [31:0] inst_t;  // one instruction word

  //////////////////////////////
  // constants
  //////////////////////////////

  // first fetch address out of reset
  localparam addr_t PC_START = 64'h8000_0000;

  // addi x0, x0, 0
  localparam inst_t INST_NOP = 32'h0000_0013;

  // default rom depth in 64-bit words
  localparam int ROM_WORDS = 16;

  // axi read response code
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage
